// ==== flist.f ====
rtl/csr_pkg.sv
rtl/csr_trap_if.sv
rtl/csr_regfile.sv
rtl/trap_ctrl.sv
rtl/riscv_core_csr_unit.sv
sim/csr_unit_checker.sv
sim/csr_unit_monitor.sv
sim/csr_unit_tb.sv

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] csr_word_t;
    typedef logic [11:0]     csr_addr_t;

    // machine information
    localparam csr_addr_t CSR_MVENDORID = 12'hf11;
    localparam csr_addr_t CSR_MARCHID   = 12'hf12;
    localparam csr_addr_t CSR_MIMPID    = 12'hf13;
    localparam csr_addr_t CSR_MHARTID   = 12'hf14;

    // trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;

    // trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // counter and timer
    localparam csr_addr_t CSR_CYCLE     = 12'hc00;
    localparam csr_addr_t CSR_TIME      = 12'hc01;
    localparam csr_addr_t CSR_MTIMECMP  = 12'hbbf;

    typedef enum logic [1:0] {
        OP_ZERO = 2'd0,   // writes zero
        OP_RW   = 2'd1,
        OP_RS   = 2'd2,
        OP_RC   = 2'd3
    } csr_op_e;

    // exception codes, interrupt flag kept apart in bit 31
    localparam logic [30:0] CAUSE_MISALIGNED  = 31'd0;
    localparam logic [30:0] CAUSE_ILLEGAL     = 31'd2;
    localparam logic [30:0] CAUSE_EBREAK      = 31'd3;
    localparam logic [30:0] CAUSE_LOAD_FAULT  = 31'd5;
    localparam logic [30:0] CAUSE_STORE_FAULT = 31'd7;
    localparam logic [30:0] CAUSE_ECALL       = 31'd11;
    localparam logic [30:0] IRQ_M_TIMER       = 31'd7;
    localparam logic [30:0] IRQ_M_EXT         = 31'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MIE_MTIE_BIT     = 7;   // mip uses the same positions
    localparam int MIE_MEIE_BIT     = 11;

    localparam logic [1:0] M_MODE = 2'b11;

    // MXL=1, extensions A C I M
    localparam csr_word_t MISA_VALUE = 32'h4000_1105;

endpackage

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile (
    input  logic                i_csr_unit_clk,
    input  logic                i_csr_unit_rst_n,
    input  logic                i_csr_wen,
    input  csr_pkg::csr_op_e    i_op,
    input  csr_pkg::csr_word_t  i_src,
    input  csr_pkg::csr_addr_t  i_addr,
    input  csr_pkg::csr_word_t  i_pc,
    input  logic                i_mexternal,
    output csr_pkg::csr_word_t  o_rdata,
    output csr_pkg::csr_word_t  o_mepc,
    csr_trap_if.regs            trap
);

    logic               mstatus_mie;
    logic               mstatus_mpie;
    logic               mie_meie;
    logic               mie_mtie;
    logic               mip_meip;
    logic               mip_mtip;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mscratch;
    csr_pkg::csr_word_t mepc;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mtval;
    csr_pkg::csr_word_t mtimecmp;
    csr_pkg::csr_word_t counter;

    csr_pkg::csr_word_t mstatus_rd;
    csr_pkg::csr_word_t mie_rd;
    csr_pkg::csr_word_t mip_rd;
    csr_pkg::csr_word_t op_result;

    // packed views of the bit-field registers
    always_comb
    begin
        mstatus_rd = '0;
        mstatus_rd[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_rd[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_rd[csr_pkg::MSTATUS_MPP_LSB +: 2] = csr_pkg::M_MODE;  // only machine mode

        mie_rd = '0;
        mie_rd[csr_pkg::MIE_MEIE_BIT] = mie_meie;
        mie_rd[csr_pkg::MIE_MTIE_BIT] = mie_mtie;

        mip_rd = '0;
        mip_rd[csr_pkg::MIE_MEIE_BIT] = mip_meip;
        mip_rd[csr_pkg::MIE_MTIE_BIT] = mip_mtip;
    end

    always_comb
    begin
        case (i_addr)
            csr_pkg::CSR_MSTATUS:  o_rdata = mstatus_rd;
            csr_pkg::CSR_MISA:     o_rdata = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MIE:      o_rdata = mie_rd;
            csr_pkg::CSR_MTVEC:    o_rdata = mtvec;
            csr_pkg::CSR_MSCRATCH: o_rdata = mscratch;
            csr_pkg::CSR_MEPC:     o_rdata = mepc;
            csr_pkg::CSR_MCAUSE:   o_rdata = mcause;
            csr_pkg::CSR_MTVAL:    o_rdata = mtval;
            csr_pkg::CSR_MIP:      o_rdata = mip_rd;
            csr_pkg::CSR_CYCLE:    o_rdata = counter;
            csr_pkg::CSR_TIME:     o_rdata = counter;
            csr_pkg::CSR_MTIMECMP: o_rdata = mtimecmp;
            default:               o_rdata = '0;  // id registers read zero
        endcase
    end

    always_comb
    begin
        case (i_op)
            csr_pkg::OP_RW: op_result = i_src;
            csr_pkg::OP_RS: op_result = o_rdata | i_src;
            csr_pkg::OP_RC: op_result = o_rdata & ~i_src;
            default:        op_result = '0;
        endcase
    end

    // mstatus, trap entry first, then mret, then csr write
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end
        else if (trap.trap_take)
        begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end
        else if (trap.mret)
        begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
        else if (i_csr_wen && i_addr == csr_pkg::CSR_MSTATUS)
        begin
            mstatus_mie  <= op_result[csr_pkg::MSTATUS_MIE_BIT];
            mstatus_mpie <= op_result[csr_pkg::MSTATUS_MPIE_BIT];
        end
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end
        else if (trap.trap_take)
        begin
            mepc   <= i_pc;
            mcause <= trap.trap_cause;
            mtval  <= trap.trap_tval;
        end
        else if (i_csr_wen)
        begin
            case (i_addr)
                csr_pkg::CSR_MEPC:   mepc   <= op_result;
                csr_pkg::CSR_MCAUSE: mcause <= op_result;
                csr_pkg::CSR_MTVAL:  mtval  <= op_result;
                default:             ;
            endcase
        end
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mie_meie <= 1'b0;
            mie_mtie <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
            mtimecmp <= '0;
        end
        else if (i_csr_wen)
        begin
            case (i_addr)
                csr_pkg::CSR_MIE:
                begin
                    mie_meie <= op_result[csr_pkg::MIE_MEIE_BIT];
                    mie_mtie <= op_result[csr_pkg::MIE_MTIE_BIT];
                end
                csr_pkg::CSR_MTVEC:    mtvec    <= op_result;
                csr_pkg::CSR_MSCRATCH: mscratch <= op_result;
                csr_pkg::CSR_MTIMECMP: mtimecmp <= op_result;
                default:               ;
            endcase
        end
    end

    // free running counter and pending bits
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            counter  <= '0;
            mip_meip <= 1'b0;
            mip_mtip <= 1'b0;
        end
        else
        begin
            counter  <= counter + 1'b1;
            mip_meip <= i_mexternal;
            mip_mtip <= (counter >= mtimecmp);
        end
    end

    assign o_mepc = mepc;

    assign trap.mstatus_mie = mstatus_mie;
    assign trap.mie_meie    = mie_meie;
    assign trap.mie_mtie    = mie_mtie;
    assign trap.mip_meip    = mip_meip;
    assign trap.mip_mtip    = mip_mtip;
    assign trap.mtvec       = mtvec;
    assign trap.mcause      = mcause;

endmodule

// ==== rtl/csr_trap_if.sv ====
`timescale 1ns/1ps

interface csr_trap_if;

    logic               trap_take;    // one cycle strobe
    csr_pkg::csr_word_t trap_cause;   // bit 31 set for interrupts
    csr_pkg::csr_word_t trap_tval;
    logic               mret;

    logic               mstatus_mie;
    logic               mie_meie;
    logic               mie_mtie;
    logic               mip_meip;
    logic               mip_mtip;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mcause;

    modport ctrl (
        output trap_take, trap_cause, trap_tval, mret,
        input  mstatus_mie, mie_meie, mie_mtie, mip_meip, mip_mtip, mtvec, mcause
    );

    modport regs (
        input  trap_take, trap_cause, trap_tval, mret,
        output mstatus_mie, mie_meie, mie_mtie, mip_meip, mip_mtip, mtvec, mcause
    );

endinterface

// ==== rtl/riscv_core_csr_unit.sv ====
`timescale 1ns/1ps

module riscv_core_csr_unit (
    input  logic         i_csr_unit_clk,
    input  logic         i_csr_unit_rst_n,
    input  logic [31:0]  i_csr_unit_pc,
    input  logic [31:0]  i_csr_unit_fault_addr,   // load or store fault address
    input  logic         i_csr_unit_mexternal,

    input  logic         i_csr_unit_csr_wen,
    input  logic [1:0]   i_csr_unit_op,
    input  logic [31:0]  i_csr_unit_src,
    input  logic [11:0]  i_csr_unit_csr_addr,

    input  logic         i_csr_unit_mret,
    input  logic         i_csr_unit_ecall,
    input  logic         i_csr_unit_ebreak,
    input  logic         i_csr_unit_illegal_instr_id,
    input  logic         i_csr_unit_illegal_instr_exe,
    input  logic         i_csr_unit_instr_addr_misaligned,
    input  logic         i_csr_unit_lw_access_fault,
    input  logic         i_csr_unit_sw_access_fault,

    output logic [31:0]  o_csr_unit_csr_rdata,
    output logic [31:0]  o_csr_unit_irq_handler,
    output logic [31:0]  o_csr_unit_rtrn_addr,
    output logic         o_csr_unit_ret_sel,
    output logic         o_csr_unit_redirect,
    output logic         o_csr_unit_ack,
    output logic         o_csr_unit_if_flush,
    output logic         o_csr_unit_id_flush,
    output logic         o_csr_unit_exe_flush,
    output logic         o_csr_unit_mem_flush
);

    csr_trap_if trap_bus ();

    csr_regfile csr_regfile_inst (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_csr_wen        (i_csr_unit_csr_wen),
        .i_op             (csr_pkg::csr_op_e'(i_csr_unit_op)),
        .i_src            (i_csr_unit_src),
        .i_addr           (i_csr_unit_csr_addr),
        .i_pc             (i_csr_unit_pc),
        .i_mexternal      (i_csr_unit_mexternal),
        .o_rdata          (o_csr_unit_csr_rdata),
        .o_mepc           (o_csr_unit_rtrn_addr),   // return target is always mepc
        .trap             (trap_bus.regs)
    );

    trap_ctrl trap_ctrl_inst (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_illegal_id     (i_csr_unit_illegal_instr_id),
        .i_illegal_exe    (i_csr_unit_illegal_instr_exe),
        .i_misaligned     (i_csr_unit_instr_addr_misaligned),
        .i_ecall          (i_csr_unit_ecall),
        .i_ebreak         (i_csr_unit_ebreak),
        .i_lw_fault       (i_csr_unit_lw_access_fault),
        .i_sw_fault       (i_csr_unit_sw_access_fault),
        .i_mret           (i_csr_unit_mret),
        .i_fault_addr     (i_csr_unit_fault_addr),
        .o_irq_handler    (o_csr_unit_irq_handler),
        .o_redirect       (o_csr_unit_redirect),
        .o_ack            (o_csr_unit_ack),
        .o_if_flush       (o_csr_unit_if_flush),
        .o_id_flush       (o_csr_unit_id_flush),
        .o_exe_flush      (o_csr_unit_exe_flush),
        .o_mem_flush      (o_csr_unit_mem_flush),
        .trap             (trap_bus.ctrl)
    );

    // pc mux select toward mepc
    assign o_csr_unit_ret_sel = i_csr_unit_mret;

endmodule

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                i_csr_unit_clk,
    input  logic                i_csr_unit_rst_n,
    input  logic                i_illegal_id,
    input  logic                i_illegal_exe,
    input  logic                i_misaligned,
    input  logic                i_ecall,
    input  logic                i_ebreak,
    input  logic                i_lw_fault,
    input  logic                i_sw_fault,
    input  logic                i_mret,
    input  csr_pkg::csr_word_t  i_fault_addr,
    output csr_pkg::csr_word_t  o_irq_handler,
    output logic                o_redirect,
    output logic                o_ack,
    output logic                o_if_flush,
    output logic                o_id_flush,
    output logic                o_exe_flush,
    output logic                o_mem_flush,
    csr_trap_if.ctrl            trap
);

    typedef enum logic {
        ST_IDLE,
        ST_REDIRECT
    } trap_state_e;

    trap_state_e        state;
    logic               ext_irq;
    logic               tmr_irq;
    logic               trap_pending;
    csr_pkg::csr_word_t cause;
    csr_pkg::csr_word_t tval;
    csr_pkg::csr_word_t tvec_base;
    logic               mem_flush;
    logic               exe_flush;
    logic               id_flush;

    assign ext_irq = trap.mstatus_mie & trap.mie_meie & trap.mip_meip;
    assign tmr_irq = trap.mstatus_mie & trap.mie_mtie & trap.mip_mtip;

    // fixed priority, interrupts ahead of exceptions
    always_comb
    begin
        trap_pending = 1'b1;
        tval         = '0;
        if (ext_irq)
            cause = {1'b1, csr_pkg::IRQ_M_EXT};
        else if (tmr_irq)
            cause = {1'b1, csr_pkg::IRQ_M_TIMER};
        else if (i_illegal_id || i_illegal_exe)
            cause = {1'b0, csr_pkg::CAUSE_ILLEGAL};
        else if (i_misaligned)
            cause = {1'b0, csr_pkg::CAUSE_MISALIGNED};
        else if (i_ecall)
            cause = {1'b0, csr_pkg::CAUSE_ECALL};
        else if (i_ebreak)
            cause = {1'b0, csr_pkg::CAUSE_EBREAK};
        else if (i_sw_fault)
        begin
            cause = {1'b0, csr_pkg::CAUSE_STORE_FAULT};
            tval  = i_fault_addr;
        end
        else if (i_lw_fault)
        begin
            cause = {1'b0, csr_pkg::CAUSE_LOAD_FAULT};
            tval  = i_fault_addr;
        end
        else
        begin
            cause        = '0;
            trap_pending = 1'b0;
        end
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (trap_pending)
                        state <= ST_REDIRECT;
                end
                default: state <= ST_IDLE;  // redirect lasts one cycle
            endcase
        end
    end

    assign trap.trap_take  = (state == ST_IDLE) && trap_pending;
    assign trap.trap_cause = cause;
    assign trap.trap_tval  = tval;
    assign trap.mret       = i_mret;

    assign o_redirect = (state == ST_REDIRECT);

    // mcause already holds the entry cause during redirect
    assign o_ack = o_redirect && (trap.mcause == {1'b1, csr_pkg::IRQ_M_EXT});

    assign tvec_base = {trap.mtvec[31:2], 2'b00};

    always_comb
    begin
        if (trap.mtvec[0] && trap.mcause[31])
            o_irq_handler = tvec_base + {trap.mcause[29:0], 2'b00};  // vectored
        else
            o_irq_handler = tvec_base;
    end

    assign mem_flush = i_lw_fault | i_sw_fault | i_mret;
    assign exe_flush = mem_flush | i_illegal_exe | i_misaligned;
    assign id_flush  = exe_flush | i_illegal_id | i_ecall | i_ebreak;

    assign o_mem_flush = mem_flush;
    assign o_exe_flush = exe_flush;
    assign o_id_flush  = id_flush;
    assign o_if_flush  = id_flush | o_redirect;

endmodule

// ==== sim/csr_unit_checker.sv ====
`timescale 1ns/1ps

module csr_unit_checker (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_redirect,
    input logic i_ack,
    input logic i_if_flush,
    input logic i_id_flush,
    input logic i_trap_take
);

    int fail_count = 0;

    redirect_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect |=> !i_redirect)
    else
    begin
        $error("redirect held longer than one cycle");
        fail_count++;
    end

    ack_in_redirect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ack |-> i_redirect)
    else
    begin
        $error("ack outside the redirect cycle");
        fail_count++;
    end

    if_covers_id: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_id_flush |-> i_if_flush)
    else
    begin
        $error("id flush without if flush");
        fail_count++;
    end

    no_take_in_redirect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect |-> !i_trap_take)
    else
    begin
        $error("trap taken during redirect");
        fail_count++;
    end

endmodule

bind trap_ctrl csr_unit_checker protocol_check (
    .i_clk       (i_csr_unit_clk),
    .i_rst_n     (i_csr_unit_rst_n),
    .i_redirect  (o_redirect),
    .i_ack       (o_ack),
    .i_if_flush  (o_if_flush),
    .i_id_flush  (o_id_flush),
    .i_trap_take (trap.trap_take)
);

// ==== sim/csr_unit_monitor.sv ====
`timescale 1ns/1ps

module csr_unit_monitor (
    input  logic            i_clk,
    input  logic            i_val_chk,
    input  logic [1:0]      i_val_sel,     // 0 rdata, 1 handler, 2 return address
    input  logic [31:0]     i_val_exp,
    input  logic            i_flag_chk,
    input  logic [6:0]      i_flag_exp,
    input  logic            i_test_end,
    input  logic [8*16-1:0] i_test_name,
    input  logic [31:0]     i_rdata,
    input  logic [31:0]     i_irq_handler,
    input  logic [31:0]     i_rtrn_addr,
    input  logic            i_ret_sel,
    input  logic            i_ack,
    input  logic            i_redirect,
    input  logic            i_if_flush,
    input  logic            i_id_flush,
    input  logic            i_exe_flush,
    input  logic            i_mem_flush,
    output int              o_tests,
    output int              o_failed
);

    int          test_errors = 0;
    logic [31:0] actual;
    logic [6:0]  flags;

    initial
    begin
        o_tests  = 0;
        o_failed = 0;
    end

    assign flags = {i_ret_sel, i_ack, i_redirect, i_if_flush, i_id_flush,
                    i_exe_flush, i_mem_flush};

    // inputs change on the falling edge, so both sides are settled here
    always @(posedge i_clk)
    begin
        if (i_val_chk)
        begin
            case (i_val_sel)
                2'd1:    actual = i_irq_handler;
                2'd2:    actual = i_rtrn_addr;
                default: actual = i_rdata;
            endcase
            if (actual !== i_val_exp)
            begin
                $display("CHECK FAILED %0s: value expected %h actual %h",
                         i_test_name, i_val_exp, actual);
                test_errors++;
            end
        end
        if (i_flag_chk && flags !== i_flag_exp)
        begin
            $display("CHECK FAILED %0s: flags expected %b actual %b",
                     i_test_name, i_flag_exp, flags);
            test_errors++;
        end
        if (i_test_end)
        begin
            o_tests++;
            if (test_errors == 0)
                $display("test %0s passed", i_test_name);
            else
            begin
                $display("test %0s failed", i_test_name);
                o_failed++;
            end
            test_errors = 0;
        end
    end

endmodule

// ==== sim/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    logic        csr_unit_clk;
    logic        csr_unit_rst_n;
    logic [31:0] pc;
    logic [31:0] fault_addr;
    logic        mexternal;
    logic        csr_wen;
    logic [1:0]  op;
    logic [31:0] src;
    logic [11:0] csr_addr;
    logic        mret;
    logic        ecall;
    logic        ebreak;
    logic        illegal_id;
    logic        illegal_exe;
    logic        misaligned;
    logic        lw_fault;
    logic        sw_fault;

    wire [31:0]  rdata;
    wire [31:0]  irq_handler;
    wire [31:0]  rtrn_addr;
    wire         ret_sel;
    wire         redirect;
    wire         ack;
    wire         if_flush;
    wire         id_flush;
    wire         exe_flush;
    wire         mem_flush;

    logic             val_chk;
    logic [1:0]       val_sel;
    logic [31:0]      val_exp;
    logic             flag_chk;
    logic [6:0]       flag_exp;
    logic             test_end;
    logic [8*16-1:0]  name;
    logic [8*16-1:0]  cmd;
    logic [8*128-1:0] line;
    logic [31:0]      addr_col;
    logic [31:0]      data_col;
    logic [31:0]      exp_col;
    int               fd;
    int               n;
    int               lines = 0;
    int               limit = 0;
    int               cycles = 0;
    int               run_cycles = 0;
    int               bad_lines = 0;
    int               tests;
    int               failed;
    int               assert_fails;

    riscv_core_csr_unit riscv_core_csr_unit_inst (
        .i_csr_unit_clk                   (csr_unit_clk),
        .i_csr_unit_rst_n                 (csr_unit_rst_n),
        .i_csr_unit_pc                    (pc),
        .i_csr_unit_fault_addr            (fault_addr),
        .i_csr_unit_mexternal             (mexternal),
        .i_csr_unit_csr_wen               (csr_wen),
        .i_csr_unit_op                    (op),
        .i_csr_unit_src                   (src),
        .i_csr_unit_csr_addr              (csr_addr),
        .i_csr_unit_mret                  (mret),
        .i_csr_unit_ecall                 (ecall),
        .i_csr_unit_ebreak                (ebreak),
        .i_csr_unit_illegal_instr_id      (illegal_id),
        .i_csr_unit_illegal_instr_exe     (illegal_exe),
        .i_csr_unit_instr_addr_misaligned (misaligned),
        .i_csr_unit_lw_access_fault       (lw_fault),
        .i_csr_unit_sw_access_fault       (sw_fault),
        .o_csr_unit_csr_rdata             (rdata),
        .o_csr_unit_irq_handler           (irq_handler),
        .o_csr_unit_rtrn_addr             (rtrn_addr),
        .o_csr_unit_ret_sel               (ret_sel),
        .o_csr_unit_redirect              (redirect),
        .o_csr_unit_ack                   (ack),
        .o_csr_unit_if_flush              (if_flush),
        .o_csr_unit_id_flush              (id_flush),
        .o_csr_unit_exe_flush             (exe_flush),
        .o_csr_unit_mem_flush             (mem_flush)
    );

    csr_unit_monitor monitor_inst (
        .i_clk         (csr_unit_clk),
        .i_val_chk     (val_chk),
        .i_val_sel     (val_sel),
        .i_val_exp     (val_exp),
        .i_flag_chk    (flag_chk),
        .i_flag_exp    (flag_exp),
        .i_test_end    (test_end),
        .i_test_name   (name),
        .i_rdata       (rdata),
        .i_irq_handler (irq_handler),
        .i_rtrn_addr   (rtrn_addr),
        .i_ret_sel     (ret_sel),
        .i_ack         (ack),
        .i_redirect    (redirect),
        .i_if_flush    (if_flush),
        .i_id_flush    (id_flush),
        .i_exe_flush   (exe_flush),
        .i_mem_flush   (mem_flush),
        .o_tests       (tests),
        .o_failed      (failed)
    );

    always #5 csr_unit_clk = ~csr_unit_clk;

    always @(posedge csr_unit_clk)
    begin
        cycles++;
        if (limit != 0 && cycles >= limit)
        begin
            $display("timeout: trace did not finish within %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // cycle counter model, counts from reset release
    always @(posedge csr_unit_clk)
    begin
        if (csr_unit_rst_n)
            run_cycles++;
    end

    // flush chain for the kind bits of the trace header
    function automatic logic [6:0] flush_flags(input logic [7:0] kind);
        logic mem;
        logic exe;
        logic id;
        mem = kind[5] | kind[6];
        exe = mem | kind[1] | kind[2];
        id  = exe | kind[0] | kind[3] | kind[4];
        flush_flags = {3'b000, id, id, exe, mem};
    endfunction

    task automatic check_output(input logic [1:0] sel, input logic [31:0] exp);
        val_chk = 1'b1;
        val_sel = sel;
        val_exp = exp;
    endtask

    task automatic expect_flags(input logic [6:0] exp);
        flag_chk = 1'b1;
        flag_exp = exp;
    endtask

    task automatic next_cycle;
        @(negedge csr_unit_clk);
        val_chk  = 1'b0;
        flag_chk = 1'b0;
        test_end = 1'b0;
        csr_wen  = 1'b0;
        mret     = 1'b0;
    endtask

    task automatic run_command;
        logic [31:0] first;
        if (cmd == "read")
        begin
            csr_addr = addr_col[11:0];
            check_output(2'd0, exp_col);
        end
        else if (cmd == "write" || cmd == "set" || cmd == "clear")
        begin
            csr_addr = addr_col[11:0];
            src      = data_col;
            csr_wen  = 1'b1;
            if (cmd == "write")
                op = csr_pkg::OP_RW;
            else if (cmd == "set")
                op = csr_pkg::OP_RS;
            else
                op = csr_pkg::OP_RC;
            check_output(2'd0, exp_col);  // old value
        end
        else if (cmd == "mret")
        begin
            mret = 1'b1;
            check_output(2'd2, exp_col);
            expect_flags(7'b1001111);
        end
        else if (cmd == "trap")
        begin
            pc         = data_col;
            fault_addr = ~data_col;
            {mexternal, lw_fault, sw_fault, ebreak, ecall} = addr_col[7:3];
            {misaligned, illegal_exe, illegal_id} = addr_col[2:0];
            expect_flags(flush_flags(addr_col[7:0]));
            next_cycle();
            while (!redirect)
                next_cycle();
            {mexternal, lw_fault, sw_fault, ebreak, ecall} = 5'b0;
            {misaligned, illegal_exe, illegal_id} = 3'b0;
            check_output(2'd1, exp_col);
            expect_flags({1'b0, addr_col[7], 5'b11000});
            next_cycle();
            expect_flags(7'b0);  // pulse gone
        end
        else if (cmd == "tick")
        begin
            csr_addr = csr_pkg::CSR_CYCLE;
            check_output(2'd0, run_cycles);
            next_cycle();
            first = run_cycles;
            repeat (data_col) next_cycle();
            check_output(2'd0, first + exp_col);
        end
        else
        begin
            $display("unknown command %0s in trace line %0s", cmd, name);
            bad_lines++;
        end
        test_end = 1'b1;
        next_cycle();
    endtask

    initial
    begin
        csr_unit_clk   = 1'b0;
        csr_unit_rst_n = 1'b0;
        pc             = '0;
        fault_addr     = '0;
        mexternal      = 1'b0;
        csr_wen        = 1'b0;
        op             = '0;
        src            = '0;
        csr_addr       = '0;
        mret           = 1'b0;
        ecall          = 1'b0;
        ebreak         = 1'b0;
        illegal_id     = 1'b0;
        illegal_exe    = 1'b0;
        misaligned     = 1'b0;
        lw_fault       = 1'b0;
        sw_fault       = 1'b0;
        val_chk        = 1'b0;
        val_sel        = '0;
        val_exp        = '0;
        flag_chk       = 1'b0;
        flag_exp       = '0;
        test_end       = 1'b0;
        name           = '0;

        fd = $fopen("sim/csr_unit_trace.txt", "r");
        while (fd != 0 && !$feof(fd))
        begin
            n = $fgets(line, fd);
            lines++;
        end
        if (fd != 0)
            $fclose(fd);
        limit = lines * 8 + 100;
        fd = $fopen("sim/csr_unit_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file");
            bad_lines++;
        end

        repeat (5) @(negedge csr_unit_clk);
        csr_unit_rst_n = 1'b1;

        while (fd != 0 && !$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0)
            begin
                n = $sscanf(line, "%s %s %h %h %h", name, cmd, addr_col, data_col, exp_col);
                if (n == 5)  // header and blank lines fall out here
                    run_command();
            end
        end
        next_cycle();

        assert_fails = riscv_core_csr_unit_inst.trap_ctrl_inst.protocol_check.fail_count;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d, bad lines %0d",
                 tests, tests - failed, failed, assert_fails, bad_lines);
        if (failed == 0 && assert_fails == 0 && bad_lines == 0 && tests > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/csr_unit_trace.txt ====
# columns: name command addr_or_kind data expected, values in hex
# trap kind bits: 0 ill_id 1 ill_exe 2 misaligned 3 ecall 4 ebreak 5 sw 6 lw 7 ext irq
misa_rd       read   301 00000000 40001105
mvendorid_rd  read   f11 00000000 00000000
scratch_rw    write  340 a5a5f00f 00000000
scratch_rs    set    340 00000ff0 a5a5f00f
scratch_rc    clear  340 a5000000 a5a5ffff
scratch_rd    read   340 00000000 00a5ffff
mtvec_rw      write  305 00001000 00000000
mtvec_rs      set    305 00000100 00001000
mtvec_rc      clear  305 00001000 00001100
mtvec_rd      read   305 00000000 00000100
mie_on        set    300 00000008 00001800
ill_trap      trap   01  00000200 00000100
ill_mepc      read   341 00000000 00000200
ill_cause     read   342 00000000 00000002
ill_tval      read   343 00000000 00000000
ill_mstatus   read   300 00000000 00001880
ill_mret      mret   000 00000000 00000200
mret_mstatus  read   300 00000000 00001888
lw_trap       trap   40  00000204 00000100
lw_tval       read   343 00000000 fffffdfb
lw_cause      read   342 00000000 00000005
sw_trap       trap   20  00000208 00000100
sw_tval       read   343 00000000 fffffdf7
sw_cause      read   342 00000000 00000007
ecall_trap    trap   08  0000020c 00000100
ecall_cause   read   342 00000000 0000000b
ecall_tval    read   343 00000000 00000000
ebreak_trap   trap   10  00000210 00000100
ebreak_cause  read   342 00000000 00000003
mis_trap      trap   04  00000214 00000100
mis_cause     read   342 00000000 00000000
exe_trap      trap   02  00000218 00000100
exe_cause     read   342 00000000 00000002
prio_trap     trap   41  0000021c 00000100
prio_cause    read   342 00000000 00000002
prio_tval     read   343 00000000 00000000
prio_mstatus  read   300 00000000 00001800
irq_vec       write  305 00000101 00000100
irq_mie       write  304 00000800 00000000
irq_mstatus   set    300 00000008 00001800
ext_trap      trap   80  00000300 0000012c
ext_cause     read   342 00000000 8000000b
ext_mepc      read   341 00000000 00000300
ext_mret      mret   000 00000000 00000300
ext_mstatus   read   300 00000000 00001888
tmr_cmp       write  bbf 00000000 00000000
tmr_mip       read   344 00000000 00000080
tmr_cycle     tick   c00 00000010 00000010
tmr_mie       write  304 00000880 00000800
tmr_trap      trap   00  00000400 0000011c
tmr_cause     read   342 00000000 80000007
tmr_mepc      read   341 00000000 00000400
